//--- Makefile
TOP := tb_sdram_cmd_watch

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f sdram_cmd_watch.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Finished with errors" sim.log; then echo "FAIL"; exit 1; fi
	@grep -q "Finished with no errors" sim.log || { echo "FAIL"; exit 1; }
	@echo "PASS"

lint:
	verilator --lint-only -Wall --timescale 1ns/1ps \
		--top-module sdram_cmd_watch -f sdram_cmd_watch.f

clean:
	rm -rf obj_dir sim.log

//--- hw/sdram_bank_tracker.sv
// open-bank bookkeeping, reports refresh with a row open and activate of an already open bank
`timescale 1ns/1ps

module sdram_bank_tracker
    import sdram_mon_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  sdram_cmd_t  cmd,
    output sdram_viol_t viol
);

    logic [NUM_BANKS-1:0] open_banks;  // bit per bank with a row open
    logic [NUM_BANKS-1:0] open_nxt;
    sdram_viol_t          viol_d;
    sdram_viol_t          viol_q;

    always_comb
    begin
        open_nxt = open_banks;
        viol_d   = '0;
        case (cmd.cmd)
            ACTIVE:
            begin
                viol_d.act_open_bank = open_banks[cmd.ba];  // row already open here
                open_nxt[cmd.ba]     = 1'b1;                // stays set either way
            end
            PRECHARGE:
            begin
                if (cmd.a10)
                    open_nxt = '0;  // precharge all
                else
                    open_nxt[cmd.ba] = 1'b0;
            end
            AUTO_REFRESH:
                viol_d.rfs_open_bank = |open_banks;
            default:
                ;  // reads, writes, nop etc leave the set alone
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            open_banks <= '0;
            viol_q     <= '0;
        end
        else
        begin
            open_banks <= open_nxt;
            viol_q     <= viol_d;  // pulse for one cycle
        end
    end

    assign viol = viol_q;

    // a single command is either a refresh or an activate
    a_viol_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(viol_q.rfs_open_bank && viol_q.act_open_bank))
        else $error("sdram_bank_tracker: both violation bits high together");

endmodule

//--- hw/sdram_cmd_decode.sv
// input stage of the watcher, samples the command pins each edge and emits one typed command
`timescale 1ns/1ps

module sdram_cmd_decode
    import sdram_mon_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cs_n,
    input  logic       ras_n,
    input  logic       cas_n,
    input  logic       we_n,
    input  logic [1:0] ba,
    input  logic       a10,
    output sdram_cmd_t cmd
);

    sdram_cmd_t cmd_d;  // decoded from the live pins
    sdram_cmd_t cmd_q;  // registered, one cycle behind the pins

    always_comb
    begin
        cmd_d.cmd = decode_pins(cs_n, ras_n, cas_n, we_n);
        cmd_d.ba  = ba;   // kept even when unused by the command
        cmd_d.a10 = a10;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cmd_q.cmd <= DESELECT;  // idle bus after reset
            cmd_q.ba  <= '0;
            cmd_q.a10 <= 1'b0;
        end
        else
            cmd_q <= cmd_d;
    end

    assign cmd = cmd_q;

    // controller must drive every pin once out of reset
    a_pins_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({cs_n, ras_n, cas_n, we_n, ba, a10}))
        else $error("sdram_cmd_decode: unknown value on command pins");

endmodule

//--- hw/sdram_cmd_watch.sv
// top of the passive SDRAM command checker, wires decode, refresh and bank checks and status
`timescale 1ns/1ps

module sdram_cmd_watch
    import sdram_mon_pkg::*;
#(
    parameter int MAX_RFS_ITV_CYC = 2232,  // 15.625 us at 7 ns
    parameter int INIT_AUTO_RFS_N = 2
)(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cs_n,
    input  logic              ras_n,
    input  logic              cas_n,
    input  logic              we_n,
    input  logic [1:0]        ba,
    input  logic              a10,
    input  logic              err_clr,
    output logic              start_rfs_timing,
    output logic              rfs_timeout,
    output sdram_mon_status_t status
);

    sdram_cmd_t  cmd;   // one cycle after the pins
    sdram_viol_t viol;  // two cycles after the pins

    sdram_cmd_decode u_decode (
        .clk   (clk),
        .rst_n (rst_n),
        .cs_n  (cs_n),
        .ras_n (ras_n),
        .cas_n (cas_n),
        .we_n  (we_n),
        .ba    (ba),
        .a10   (a10),
        .cmd   (cmd)
    );

    sdram_rfs_monitor #(
        .MAX_RFS_ITV_CYC (MAX_RFS_ITV_CYC),
        .INIT_AUTO_RFS_N (INIT_AUTO_RFS_N)
    ) u_rfs_mon (
        .clk              (clk),
        .rst_n            (rst_n),
        .cmd              (cmd),
        .start_rfs_timing (start_rfs_timing),
        .rfs_timeout      (rfs_timeout)
    );

    sdram_bank_tracker u_bank_trk (
        .clk   (clk),
        .rst_n (rst_n),
        .cmd   (cmd),
        .viol  (viol)
    );

    sdram_mon_status u_status (
        .clk         (clk),
        .rst_n       (rst_n),
        .err_clr     (err_clr),
        .cmd         (cmd),
        .rfs_timeout (rfs_timeout),
        .viol        (viol),
        .status      (status)
    );

endmodule

//--- hw/sdram_mon_pkg.sv
// shared command, violation and status types for the SDRAM command watcher, imported by each block
package sdram_mon_pkg;

    localparam int NUM_BANKS   = 4;   // banks tracked for open rows
    localparam int RFS_COUNT_W = 16;  // width of the saturating refresh count

    // commands as seen on the pins
    typedef enum logic [3:0] {
        NOP          = 4'd0,
        ACTIVE       = 4'd1,
        READ         = 4'd2,
        WRITE        = 4'd3,
        BURST_TERM   = 4'd4,
        PRECHARGE    = 4'd5,
        AUTO_REFRESH = 4'd6,
        LOAD_MODE    = 4'd7,
        DESELECT     = 4'd8   // cs_n high, pins ignored
    } sdram_cmd_e;

    typedef struct packed {
        sdram_cmd_e                   cmd;
        logic [$clog2(NUM_BANKS)-1:0] ba;
        logic                         a10;  // all-banks select on precharge
    } sdram_cmd_t;

    // one-cycle pulses from the bank tracker
    typedef struct packed {
        logic rfs_open_bank;
        logic act_open_bank;
    } sdram_viol_t;

    typedef struct packed {
        logic                   rfs_timeout_seen;
        logic                   rfs_open_bank_seen;
        logic                   act_open_bank_seen;
        logic [RFS_COUNT_W-1:0] rfs_count;
    } sdram_mon_status_t;

    // JEDEC truth table on {ras_n, cas_n, we_n}
    function automatic sdram_cmd_e decode_pins(input logic cs_n, input logic ras_n,
                                               input logic cas_n, input logic we_n);
        sdram_cmd_e c;
        if (cs_n)
            c = DESELECT;
        else
        begin
            case ({ras_n, cas_n, we_n})
                3'b111:  c = NOP;
                3'b011:  c = ACTIVE;
                3'b101:  c = READ;
                3'b100:  c = WRITE;
                3'b110:  c = BURST_TERM;
                3'b010:  c = PRECHARGE;
                3'b001:  c = AUTO_REFRESH;
                default: c = LOAD_MODE;   // 000
            endcase
        end
        return c;
    endfunction

endpackage

//--- hw/sdram_mon_status.sv
// result stage, sticky error flags and a saturating refresh count, cleared by err_clr
`timescale 1ns/1ps

module sdram_mon_status
    import sdram_mon_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              err_clr,      // level, clears while high
    input  sdram_cmd_t        cmd,
    input  logic              rfs_timeout,
    input  sdram_viol_t       viol,
    output sdram_mon_status_t status
);

    logic              rfs_seen_q;  // refresh delayed one stage, lines up with viol
    sdram_mon_status_t status_q;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            rfs_seen_q <= 1'b0;
        else
            rfs_seen_q <= (cmd.cmd == AUTO_REFRESH);
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            status_q <= '0;
        else if (err_clr)
            status_q <= '0;  // clear beats a same-cycle set
        else
        begin
            if (rfs_timeout)
                status_q.rfs_timeout_seen <= 1'b1;
            if (viol.rfs_open_bank)
                status_q.rfs_open_bank_seen <= 1'b1;
            if (viol.act_open_bank)
                status_q.act_open_bank_seen <= 1'b1;
            // hold at all ones
            if (rfs_seen_q && (status_q.rfs_count != {RFS_COUNT_W{1'b1}}))
                status_q.rfs_count <= status_q.rfs_count + 1'b1;
        end
    end

    assign status = status_q;

endmodule

//--- hw/sdram_rfs_monitor.sv
// refresh checker, flags the start of refresh timing after init and any over-long refresh gap
`timescale 1ns/1ps

module sdram_rfs_monitor
    import sdram_mon_pkg::*;
#(
    parameter int MAX_RFS_ITV_CYC = 2232,  // allowed refresh gap in cycles
    parameter int INIT_AUTO_RFS_N = 2      // refreshes issued during init
)(
    input  logic       clk,
    input  logic       rst_n,
    input  sdram_cmd_t cmd,
    output logic       start_rfs_timing,
    output logic       rfs_timeout
);

    localparam int CNT_W = (MAX_RFS_ITV_CYC > 2) ? $clog2(MAX_RFS_ITV_CYC) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(MAX_RFS_ITV_CYC - 1);

    logic                     is_rfs;
    logic [INIT_AUTO_RFS_N:0] init_rfs_oh;  // one-hot, bit n means n init refreshes seen
    logic                     start_q;
    logic                     monitor_en;   // sticky once init is done
    logic [CNT_W-1:0]         itv_cnt;      // cycles since last refresh
    logic                     itv_suspend;  // counter parked at CNT_LAST
    logic                     timeout_q;

    assign is_rfs = (cmd.cmd == AUTO_REFRESH);

    // marker walks up once per init refresh, stops at the top bit
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            init_rfs_oh <= {{INIT_AUTO_RFS_N{1'b0}}, 1'b1};
        else if (is_rfs && !init_rfs_oh[INIT_AUTO_RFS_N])
            init_rfs_oh <= {init_rfs_oh[INIT_AUTO_RFS_N-1:0], 1'b0};
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            start_q <= 1'b0;
        else
            start_q <= is_rfs & init_rfs_oh[INIT_AUTO_RFS_N-1];  // last init refresh only
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            monitor_en <= 1'b0;
        else if (!monitor_en)
            monitor_en <= start_q;  // one cycle after the pulse
    end

    // any refresh restarts the gap, even before enable
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            itv_cnt     <= '0;
            itv_suspend <= 1'b0;
        end
        else if (is_rfs)
        begin
            itv_cnt     <= '0;
            itv_suspend <= 1'b0;
        end
        else if (monitor_en && !itv_suspend)
        begin
            itv_cnt     <= itv_cnt + 1'b1;
            itv_suspend <= (itv_cnt == CNT_LAST - 1'b1);  // park on the limit
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            timeout_q <= 1'b0;
        else
            timeout_q <= (itv_cnt == CNT_LAST);  // drops the edge after the refresh clears cnt
    end

    assign start_rfs_timing = start_q;
    assign rfs_timeout      = timeout_q;

    // init count can only be crossed once
    a_start_single: assert property (@(posedge clk) disable iff (!rst_n)
        start_q |=> !start_q)
        else $error("sdram_rfs_monitor: start_rfs_timing high two cycles running");

    a_timeout_enabled: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(timeout_q) |-> monitor_en)
        else $error("sdram_rfs_monitor: rfs_timeout rose before refresh timing started");

endmodule

//--- sdram_cmd_watch.f
+incdir+include
hw/sdram_mon_pkg.sv
hw/sdram_cmd_decode.sv
hw/sdram_rfs_monitor.sv
hw/sdram_bank_tracker.sv
hw/sdram_mon_status.sv
hw/sdram_cmd_watch.sv
verif/tb_sdram_cmd_watch.sv

//--- include/sdram_mon_model.svh
// cycle model of the watcher, included in the testbench module and advanced once per rising edge
`ifndef SDRAM_MON_MODEL_SVH
`define SDRAM_MON_MODEL_SVH

// needs sdram_mon_pkg, MAX_ITV and INIT_N visible where it is included
sdram_cmd_t           mdl_cmd;        // decode stage
int                   mdl_init_seen;  // init refreshes counted so far
int                   mdl_cnt;        // cycles since last refresh
bit                   mdl_start;
bit                   mdl_en;
bit                   mdl_susp;
bit                   mdl_tmo;
logic [NUM_BANKS-1:0] mdl_open;       // banks with a row open
sdram_viol_t          mdl_viol;
bit                   mdl_rfs_q;      // refresh lined up with viol
sdram_mon_status_t    mdl_status;

function automatic void reset_model();
    mdl_cmd       = '{cmd: DESELECT, ba: '0, a10: 1'b0};
    mdl_init_seen = 0;
    mdl_cnt       = 0;
    mdl_start     = 0;
    mdl_en        = 0;
    mdl_susp      = 0;
    mdl_tmo       = 0;
    mdl_open      = '0;
    mdl_viol      = '0;
    mdl_rfs_q     = 0;
    mdl_status    = '0;
endfunction

// later stages first so each reads the old value of the stage before
function automatic void advance_model(sdram_cmd_e c, logic [1:0] b, logic a, logic clr);
    bit is_rfs;
    is_rfs = (mdl_cmd.cmd == AUTO_REFRESH);
    if (clr)
        mdl_status = '0;
    else
    begin
        mdl_status.rfs_timeout_seen   |= mdl_tmo;
        mdl_status.rfs_open_bank_seen |= mdl_viol.rfs_open_bank;
        mdl_status.act_open_bank_seen |= mdl_viol.act_open_bank;
        if (mdl_rfs_q && mdl_status.rfs_count != '1)
            mdl_status.rfs_count++;
    end
    mdl_rfs_q = is_rfs;
    mdl_viol  = '0;
    if (is_rfs)
        mdl_viol.rfs_open_bank = |mdl_open;
    if (mdl_cmd.cmd == ACTIVE)
    begin
        mdl_viol.act_open_bank = mdl_open[mdl_cmd.ba];
        mdl_open[mdl_cmd.ba]   = 1'b1;
    end
    if (mdl_cmd.cmd == PRECHARGE)
        mdl_open = mdl_cmd.a10 ? '0 : (mdl_open & ~(NUM_BANKS'(1) << mdl_cmd.ba));
    mdl_tmo = (mdl_cnt == MAX_ITV - 1);
    if (is_rfs)
    begin
        mdl_cnt  = 0;
        mdl_susp = 0;
    end
    else if (mdl_en && !mdl_susp)
    begin
        mdl_susp = (mdl_cnt + 1 == MAX_ITV - 1);
        mdl_cnt++;
    end
    mdl_en    = mdl_en | mdl_start;
    mdl_start = is_rfs && (mdl_init_seen == INIT_N - 1);
    if (is_rfs && mdl_init_seen < INIT_N)
        mdl_init_seen++;
    mdl_cmd = '{cmd: c, ba: b, a10: a};  // command the testbench put on the pins
endfunction

`endif

//--- verif/tb_sdram_cmd_watch.sv
// testbench for the SDRAM command watcher, directed scenarios then a seeded random run vs the model
`timescale 1ns/1ps

module tb_sdram_cmd_watch
    import sdram_mon_pkg::*;
();

    localparam int MAX_ITV = 40;  // short gap limit keeps the run small
    localparam int INIT_N  = 2;

    `include "sdram_mon_model.svh"

    logic              clk;
    logic              rst_n;
    logic              cs_n;
    logic              ras_n;
    logic              cas_n;
    logic              we_n;
    logic [1:0]        ba;
    logic              a10;
    logic              err_clr;
    logic              start_rfs_timing;
    logic              rfs_timeout;
    sdram_mon_status_t status;

    sdram_cmd_e     pin_cmd;          // command now on the pins
    int unsigned    rand_state = 21;  // lcg seed
    int             errors;
    int             checks;
    int             tests;
    int             test_start_err;   // error count when the current test began
    int             start_pulses;

    sdram_cmd_watch #(
        .MAX_RFS_ITV_CYC (MAX_ITV),
        .INIT_AUTO_RFS_N (INIT_N)
    ) u_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    function automatic int unsigned next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state >> 16;  // low bits of an lcg are weak
    endfunction

    task automatic check_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Error at %0t ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_status(sdram_mon_status_t got, sdram_mon_status_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Error at %0t ns: status got %h expected %h", $time, got, exp);
        end
    endtask

    // cycle counts and pulse counts from directed tests
    task automatic check_count(string name, int got, int exp);
        checks++;
        if (got != exp)
        begin
            errors++;
            $display("Error at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // JEDEC pin pattern for a command
    task automatic set_pins(sdram_cmd_e c, logic [1:0] b, logic a);
        pin_cmd = c;
        ba      = b;
        a10     = a;
        cs_n    = 1'b0;
        case (c)
            NOP:          {ras_n, cas_n, we_n} = 3'b111;
            ACTIVE:       {ras_n, cas_n, we_n} = 3'b011;
            READ:         {ras_n, cas_n, we_n} = 3'b101;
            WRITE:        {ras_n, cas_n, we_n} = 3'b100;
            BURST_TERM:   {ras_n, cas_n, we_n} = 3'b110;
            PRECHARGE:    {ras_n, cas_n, we_n} = 3'b010;
            AUTO_REFRESH: {ras_n, cas_n, we_n} = 3'b001;
            LOAD_MODE:    {ras_n, cas_n, we_n} = 3'b000;
            default:
            begin
                cs_n                 = 1'b1;  // deselect
                {ras_n, cas_n, we_n} = 3'b111;
            end
        endcase
    endtask

    // one bus cycle, pins were set on the falling edge
    task automatic tick();
        @(posedge clk);
        advance_model(pin_cmd, ba, a10, err_clr);  // same cycle the dut sampled
        @(negedge clk);
        check_bit("start_rfs_timing", start_rfs_timing, mdl_start);
        check_bit("rfs_timeout", rfs_timeout, mdl_tmo);
        check_status(status, mdl_status);
        if (start_rfs_timing)
            start_pulses++;
    endtask

    task automatic issue(sdram_cmd_e c, logic [1:0] b = 2'd0, logic a = 1'b0);
        set_pins(c, b, a);
        tick();
    endtask

    task automatic idle(int n);
        repeat (n)
            issue(NOP);
    endtask

    // clear acts on the first edge, status is zero right after it
    task automatic clear_status();
        err_clr = 1'b1;
        issue(NOP);
        err_clr = 1'b0;
        check_status(status, '0);
    endtask

    task automatic wait_timeout_rise(int limit, output int cycles);
        cycles = 0;
        while (!rfs_timeout && cycles < limit)
        begin
            idle(1);
            cycles++;
        end
        if (!rfs_timeout)
        begin
            errors++;
            $display("rfs_timeout did not rise within %0d cycles", limit);
        end
    endtask

    task automatic end_test(string name);
        tests++;
        $display("test %-10s %s, %0d errors", name,
                 (errors == test_start_err) ? "ok" : "FAILED", errors - test_start_err);
        test_start_err = errors;
    endtask

    initial
    begin
        int         n;
        int         r;
        sdram_cmd_e c;
        rst_n          = 1'b0;
        cs_n           = 1'b1;
        ras_n          = 1'b1;
        cas_n          = 1'b1;
        we_n           = 1'b1;
        ba             = 2'd0;
        a10            = 1'b0;
        err_clr        = 1'b0;
        pin_cmd        = DESELECT;
        errors         = 0;
        checks         = 0;
        tests          = 0;
        test_start_err = 0;
        start_pulses   = 0;
        reset_model();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // second refresh hits the pins, pulse is seen two edges on
        issue(AUTO_REFRESH);
        idle(3);
        issue(AUTO_REFRESH);
        idle(1);
        check_bit("start_rfs_timing", start_rfs_timing, 1'b1);
        idle(4);
        issue(AUTO_REFRESH);  // later refreshes never pulse again
        idle(3);
        check_count("start pulses", start_pulses, 1);
        end_test("init");

        // one edge to decode, MAX-1 counts to park, one edge to flag
        issue(AUTO_REFRESH);
        wait_timeout_rise(3 * MAX_ITV, n);
        check_count("refresh gap cycles", n, MAX_ITV + 1);
        idle(5);
        check_bit("rfs_timeout", rfs_timeout, 1'b1);  // level holds
        issue(AUTO_REFRESH);
        idle(1);
        check_bit("rfs_timeout", rfs_timeout, 1'b1);
        idle(1);
        check_bit("rfs_timeout", rfs_timeout, 1'b0);  // gone two edges after refresh
        check_bit("status.rfs_timeout_seen", status.rfs_timeout_seen, 1'b1);
        end_test("interval");

        clear_status();
        issue(ACTIVE, 2'd2);
        issue(AUTO_REFRESH);
        idle(3);
        check_bit("status.rfs_open_bank_seen", status.rfs_open_bank_seen, 1'b1);
        issue(PRECHARGE, 2'd2, 1'b0);  // single bank close
        clear_status();
        issue(AUTO_REFRESH);
        idle(3);
        check_bit("status.rfs_open_bank_seen", status.rfs_open_bank_seen, 1'b0);
        end_test("open_row");

        clear_status();
        issue(ACTIVE, 2'd1);
        issue(ACTIVE, 2'd1);
        idle(3);
        check_bit("status.act_open_bank_seen", status.act_open_bank_seen, 1'b1);
        issue(PRECHARGE, 2'd3, 1'b1);  // all banks, ba ignored
        clear_status();
        issue(ACTIVE, 2'd1);
        idle(3);
        check_bit("status.act_open_bank_seen", status.act_open_bank_seen, 1'b0);
        issue(PRECHARGE, 2'd0, 1'b1);
        idle(2);
        end_test("double_act");

        clear_status();
        repeat (5)
        begin
            issue(AUTO_REFRESH);
            idle(2);
        end
        idle(2);
        check_count("status.rfs_count", int'(status.rfs_count), 5);
        clear_status();
        end_test("counter");

        // refresh at 2 percent, gaps often run past the limit
        repeat (3000)
        begin
            r       = next_rand() % 100;
            err_clr = (next_rand() % 97 == 0);
            if (r < 2)
                c = AUTO_REFRESH;
            else if (r < 12)
                c = ACTIVE;
            else if (r < 20)
                c = PRECHARGE;
            else if (r < 30)
                c = READ;
            else if (r < 40)
                c = WRITE;
            else if (r < 42)
                c = BURST_TERM;
            else if (r < 43)
                c = LOAD_MODE;
            else if (r < 53)
                c = DESELECT;
            else
                c = NOP;
            issue(c, 2'(next_rand() % 4), 1'(next_rand() % 2));
        end
        err_clr = 1'b0;
        end_test("random");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule
